//--- sim.f
verilog/lsu_pkg.sv
verilog/age_comparator.sv
verilog/store_queue.sv
verilog/load_queue.sv
verilog/order_failure_detector.sv
verilog/lsu_searcher_top.sv
tests/lsu_searcher_tb.sv

//--- tests/lsu_searcher_tb.sv
// testbench for the lsu searcher, directed and random traffic checked against a ring model
`timescale 1ns/1ps

module lsu_searcher_tb
	import lsu_pkg::*; ();

	// directed phases plus the random mix stay well below this
	localparam int MAX_CYCLES = 3000;
	localparam int RANDOM_CYCLES = 2000;
	localparam addr_t ADDR_A = 32'h0000_1000;
	localparam addr_t ADDR_B = 32'h0000_1040;

	logic clk;
	logic rst_n;
	logic st_alloc;
	addr_t st_addr;
	logic st_commit;
	logic ld_alloc;
	addr_t ld_addr;
	logic ld_exec;
	ldq_idx_t ld_exec_index;
	logic ld_fwd;
	stq_idx_t ld_fwd_index;
	logic ld_retire;
	logic st_full;
	logic ld_full;
	ldq_idx_t ld_alloc_index;
	logic [LDQ_SIZE-1:0] order_failures;

	// model of the store ring
	stq_idx_t s_head;
	stq_idx_t s_tail;
	int s_count;
	logic [STQ_SIZE-1:0] s_valid;
	addr_t s_addr [STQ_SIZE];

	// model of the load ring
	ldq_idx_t l_head;
	ldq_idx_t l_tail;
	int l_count;
	logic [LDQ_SIZE-1:0] l_valid;
	logic [LDQ_SIZE-1:0] l_succ;
	logic [LDQ_SIZE-1:0] l_fwd;
	addr_t l_addr [LDQ_SIZE];
	logic [STQ_SIZE-1:0] l_mask [LDQ_SIZE];
	stq_idx_t l_fidx [LDQ_SIZE];

	// mask the DUT should show now, and the one predicted for the next cycle
	logic [LDQ_SIZE-1:0] exp_now;
	logic [LDQ_SIZE-1:0] exp_next;
	logic checking;
	string test_name;
	int cycle_count;

	lsu_searcher_top lsu_searcher_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.st_alloc(st_alloc),
		.st_addr(st_addr),
		.st_commit(st_commit),
		.ld_alloc(ld_alloc),
		.ld_addr(ld_addr),
		.ld_exec(ld_exec),
		.ld_exec_index(ld_exec_index),
		.ld_fwd(ld_fwd),
		.ld_fwd_index(ld_fwd_index),
		.ld_retire(ld_retire),
		.st_full(st_full),
		.ld_full(ld_full),
		.ld_alloc_index(ld_alloc_index),
		.order_failures(order_failures)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic end_with_failure();
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_mask(input string name, input logic [LDQ_SIZE-1:0] exp,
		input logic [LDQ_SIZE-1:0] act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			end_with_failure();
		end
	endtask

	task automatic check_idx(input string name, input ldq_idx_t exp, input ldq_idx_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
			end_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			end_with_failure();
		end
	endtask

	// b older than a when it sits closer to the head of the ring
	function automatic logic is_older(input stq_idx_t b, input stq_idx_t a, input stq_idx_t head);
		stq_idx_t dist_b;
		stq_idx_t dist_a;
		dist_b = b - head;
		dist_a = a - head;
		return dist_b < dist_a;
	endfunction

	// expected failure mask for a search against the current model state
	function automatic logic [LDQ_SIZE-1:0] expected_failures(input logic commit,
		input stq_idx_t cidx);
		logic [LDQ_SIZE-1:0] mask;
		mask = '0;
		for (int i = 0; i < LDQ_SIZE; i++) begin
			if (commit && l_valid[i] && l_succ[i] && l_mask[i][cidx]
				&& l_addr[i] == s_addr[cidx]) begin
				// forwarding from the committing store or a younger one hides the hazard
				if (!l_fwd[i] || is_older(l_fidx[i], cidx, s_head)) begin
					mask[i] = 1'b1;
				end
			end
		end
		return mask;
	endfunction

	// apply the inputs held over the last edge to the model
	task automatic advance_model(input logic commit);
		logic [STQ_SIZE-1:0] cbit;
		cbit = commit ? (STQ_SIZE'(1) << s_head) : '0;
		for (int i = 0; i < LDQ_SIZE; i++) begin
			l_mask[i] = l_mask[i] & ~cbit;
		end
		l_succ = l_succ & ~exp_now;
		if (ld_retire) begin
			l_valid[l_head] = 1'b0;
			l_succ[l_head] = 1'b0;
			l_head = l_head + ldq_idx_t'(1);
		end
		// snapshot uses the store ring before this edge, minus the committing store
		if (ld_alloc) begin
			l_valid[l_tail] = 1'b1;
			l_succ[l_tail] = 1'b0;
			l_fwd[l_tail] = 1'b0;
			l_mask[l_tail] = s_valid & ~cbit;
			l_addr[l_tail] = ld_addr;
			l_tail = l_tail + ldq_idx_t'(1);
		end
		if (ld_exec) begin
			l_succ[ld_exec_index] = 1'b1;
			l_fwd[ld_exec_index] = ld_fwd;
			l_fidx[ld_exec_index] = ld_fwd_index;
		end
		l_count = l_count + int'(ld_alloc) - int'(ld_retire);
		if (commit) begin
			s_valid[s_head] = 1'b0;
			s_head = s_head + stq_idx_t'(1);
		end
		if (st_alloc) begin
			s_valid[s_tail] = 1'b1;
			s_addr[s_tail] = st_addr;
			s_tail = s_tail + stq_idx_t'(1);
		end
		s_count = s_count + int'(st_alloc) - int'(commit);
	endtask

	// one cycle: predict, take the edge, update the model, release strobes
	task automatic tick();
		logic commit;
		commit = st_commit && (s_count != 0);
		exp_next = expected_failures(commit, s_head);
		@(posedge clk);
		advance_model(commit);
		exp_now = exp_next;
		#1;
		st_alloc = 1'b0;
		st_commit = 1'b0;
		ld_alloc = 1'b0;
		ld_exec = 1'b0;
		ld_retire = 1'b0;
	endtask

	task automatic store_alloc(input addr_t addr);
		st_alloc = 1'b1;
		st_addr = addr;
		tick();
	endtask

	task automatic store_commit();
		st_commit = 1'b1;
		tick();
	endtask

	task automatic load_alloc(input addr_t addr);
		ld_alloc = 1'b1;
		ld_addr = addr;
		tick();
	endtask

	task automatic load_exec(input ldq_idx_t idx, input logic fwd, input stq_idx_t fidx);
		ld_exec = 1'b1;
		ld_exec_index = idx;
		ld_fwd = fwd;
		ld_fwd_index = fidx;
		tick();
	endtask

	task automatic load_retire();
		ld_retire = 1'b1;
		tick();
	endtask

	task automatic idle(input int n);
		repeat (n) tick();
	endtask

	function automatic addr_t pool_addr();
		return ADDR_A + addr_t'(32'h40 * ($urandom % 4));
	endfunction

	// outputs are compared mid-cycle, well away from both edges
	always @(negedge clk) begin
		if (checking) begin
			check_mask({test_name, " order_failures"}, exp_now, order_failures);
			check_flag({test_name, " st_full"}, s_count == STQ_SIZE, st_full);
			check_flag({test_name, " ld_full"}, l_count == LDQ_SIZE, ld_full);
			check_idx({test_name, " ld_alloc_index"}, l_tail, ld_alloc_index);
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			end_with_failure();
		end
	end

	initial begin
		void'($urandom(32'h0ab2_c06c));
		rst_n = 1'b0;
		st_alloc = 1'b0;
		st_addr = '0;
		st_commit = 1'b0;
		ld_alloc = 1'b0;
		ld_addr = '0;
		ld_exec = 1'b0;
		ld_exec_index = '0;
		ld_fwd = 1'b0;
		ld_fwd_index = '0;
		ld_retire = 1'b0;
		cycle_count = 0;
		checking = 1'b0;
		test_name = "reset";
		s_head = '0;
		s_tail = '0;
		s_count = 0;
		s_valid = '0;
		l_head = '0;
		l_tail = '0;
		l_count = 0;
		l_valid = '0;
		l_succ = '0;
		l_fwd = '0;
		for (int i = 0; i < LDQ_SIZE; i++) begin
			l_mask[i] = '0;
		end
		exp_now = '0;
		exp_next = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		checking = 1'b1;
		check_mask("reset", '0, order_failures);
		check_flag("reset", 1'b0, st_full);
		check_flag("reset", 1'b0, ld_full);
		check_idx("reset", '0, ld_alloc_index);

		// fill and drain both rings, the load tail wraps back to 0
		test_name = "fullness";
		repeat (STQ_SIZE) store_alloc(ADDR_A);
		check_flag("fullness st_full set", 1'b1, st_full);
		store_commit();
		check_flag("fullness st_full clear", 1'b0, st_full);
		repeat (STQ_SIZE - 1) store_commit();
		repeat (LDQ_SIZE) load_alloc(ADDR_B);
		check_flag("fullness ld_full set", 1'b1, ld_full);
		check_idx("fullness wrap", '0, ld_alloc_index);
		load_retire();
		check_flag("fullness ld_full clear", 1'b0, ld_full);
		repeat (LDQ_SIZE - 1) load_retire();

		// load 0 is older than the store, load 2 differs, load 3 never executes
		test_name = "basic failure";
		load_alloc(ADDR_A);
		store_alloc(ADDR_A);
		load_alloc(ADDR_A);
		load_alloc(ADDR_B);
		load_alloc(ADDR_A);
		load_exec(0, 1'b0, 0);
		load_exec(1, 1'b0, 0);
		load_exec(2, 1'b0, 0);
		store_commit();
		check_mask("basic failure flagged", 8'h02, order_failures);
		idle(1);
		check_mask("basic failure one cycle", 8'h00, order_failures);
		repeat (4) load_retire();

		// load 4 sees stores 1 to 3 as older
		test_name = "replay";
		repeat (3) store_alloc(ADDR_A);
		load_alloc(ADDR_A);
		load_exec(4, 1'b0, 0);
		store_commit();
		check_mask("replay first commit", 8'h10, order_failures);
		for (int i = 0; i < LDQ_SIZE; i++) begin
			check_flag("replay mask bit cleared", 1'b0,
				lsu_searcher_top_i.load_queue_entries[i].store_mask[1]);
		end
		idle(1);
		store_commit();
		check_mask("replay not executed", 8'h00, order_failures);
		load_exec(4, 1'b0, 0);
		store_commit();
		check_mask("replay after execute", 8'h10, order_failures);
		idle(1);
		load_retire();

		// stores 4 to 6, loads 5 to 7 forward, load 0 reads the cache
		test_name = "forward";
		repeat (3) store_alloc(ADDR_A);
		repeat (4) load_alloc(ADDR_A);
		load_exec(5, 1'b1, 6);
		load_exec(6, 1'b1, 4);
		// index 3 sits behind the head, nothing measures older than the committing head
		load_exec(7, 1'b1, 3);
		load_exec(0, 1'b0, 0);
		store_commit();
		check_mask("forward only cache load", 8'h01, order_failures);
		idle(1);

		// legal random traffic, compared each cycle against the model
		test_name = "random";
		for (int c = 0; c < RANDOM_CYCLES; c++) begin
			st_alloc = (s_count < STQ_SIZE) && ($urandom % 3 == 0);
			st_addr = pool_addr();
			st_commit = (s_count > 0) && ($urandom % 3 == 0);
			ld_alloc = (l_count < LDQ_SIZE) && ($urandom % 3 == 0);
			ld_addr = pool_addr();
			ld_retire = (l_count > 0) && ($urandom % 4 == 0);
			ld_exec = (l_count > 0) && ($urandom % 2 == 0);
			ld_exec_index = l_head + ldq_idx_t'($urandom % ((l_count == 0) ? 1 : l_count));
			ld_fwd = ($urandom % 3 == 0);
			ld_fwd_index = stq_idx_t'($urandom % STQ_SIZE);
			tick();
		end
		idle(2);

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- verilog/lsu_searcher_top.sv
// lsu searcher top level, joins store queue, load queue and order failure detector
`timescale 1ns/1ps

module lsu_searcher_top
	import lsu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic st_alloc,
	input addr_t st_addr,
	input logic st_commit,
	input logic ld_alloc,
	input addr_t ld_addr,
	input logic ld_exec,
	input ldq_idx_t ld_exec_index,
	input logic ld_fwd,
	input stq_idx_t ld_fwd_index,
	input logic ld_retire,
	output logic st_full,
	output logic ld_full,
	output ldq_idx_t ld_alloc_index,
	// flush request, also fed back so flagged loads replay
	output logic [LDQ_SIZE-1:0] order_failures
);

	store_queue_entry [STQ_SIZE-1:0] store_queue_entries;
	load_queue_entry [LDQ_SIZE-1:0] load_queue_entries;
	stq_idx_t stq_head;
	logic [STQ_SIZE-1:0] stq_valid_mask;
	logic stq_commit;
	stq_idx_t stq_commit_index;

	store_queue store_queue_i (
		.clk(clk),
		.rst_n(rst_n),
		.st_alloc(st_alloc),
		.st_addr(st_addr),
		.st_commit(st_commit),
		.store_queue_entries(store_queue_entries),
		.stq_head(stq_head),
		.stq_valid_mask(stq_valid_mask),
		.stq_commit(stq_commit),
		.stq_commit_index(stq_commit_index),
		.st_full(st_full)
	);

	load_queue load_queue_i (
		.clk(clk),
		.rst_n(rst_n),
		.ld_alloc(ld_alloc),
		.ld_addr(ld_addr),
		.ld_exec(ld_exec),
		.ld_exec_index(ld_exec_index),
		.ld_fwd(ld_fwd),
		.ld_fwd_index(ld_fwd_index),
		.ld_retire(ld_retire),
		.stq_valid_mask(stq_valid_mask),
		.stq_commit(stq_commit),
		.stq_commit_index(stq_commit_index),
		.order_failures(order_failures),
		.load_queue_entries(load_queue_entries),
		.ld_alloc_index(ld_alloc_index),
		.ld_full(ld_full)
	);

	order_failure_detector order_failure_detector_i (
		.clk(clk),
		.rst_n(rst_n),
		.load_queue_entries(load_queue_entries),
		.store_queue_entries(store_queue_entries),
		.stq_head(stq_head),
		.stq_commit(stq_commit),
		.stq_commit_index(stq_commit_index),
		.order_failures(order_failures)
	);

endmodule

//--- verilog/order_failure_detector.sv
// searches the load queue on every store commit and flags loads that read stale data
`timescale 1ns/1ps

module order_failure_detector
	import lsu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input load_queue_entry [LDQ_SIZE-1:0] load_queue_entries,
	input store_queue_entry [STQ_SIZE-1:0] store_queue_entries,
	// reference point for the age compare
	input stq_idx_t stq_head,
	// high only when stq_commit_index really commits this cycle
	input logic stq_commit,
	input stq_idx_t stq_commit_index,
	// one cycle after the commit, one bit per load to replay
	output logic [LDQ_SIZE-1:0] order_failures
);

	logic [LDQ_SIZE-1:0] fwd_older;
	logic [LDQ_SIZE-1:0] ld_valid;
	logic [LDQ_SIZE-1:0] fail_next;
	addr_t commit_addr;

	// one compare per load, b older than a means the forward came from before the commit
	for (genvar g = 0; g < LDQ_SIZE; g++) begin : g_age
		age_comparator #(
			.N($bits(stq_idx_t))
		) age_comparator_i (
			.head(stq_head),
			.a(stq_commit_index),
			.b(load_queue_entries[g].forward_stq_index),
			.result(fwd_older[g])
		);
	end

	assign commit_addr = store_queue_entries[stq_commit_index].address;

	always_comb begin
		for (int i = 0; i < LDQ_SIZE; i++) begin
			ld_valid[i] = load_queue_entries[i].valid;
			// younger load with data, same address, not fed by this store or a younger one
			fail_next[i] = stq_commit
				&& ld_valid[i]
				&& load_queue_entries[i].succeeded
				&& load_queue_entries[i].store_mask[stq_commit_index]
				&& (load_queue_entries[i].address == commit_addr)
				&& (!load_queue_entries[i].forward_stq_data || fwd_older[i]);
		end
	end

	// mask registered so the load queue sees it one cycle later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			order_failures <= '0;
		end else begin
			order_failures <= fail_next;
		end
	end

	// a flagged load must have been live when the search ran
	a_fail_on_valid_load: assert property (
		@(posedge clk) disable iff (!rst_n)
		(order_failures & ~$past(ld_valid)) == '0
	) else $error("order failure flagged for a load that was not valid");

endmodule

//--- verilog/load_queue.sv
// load ring that tracks execution, forwarding and the older store snapshot of each load
`timescale 1ns/1ps

module load_queue
	import lsu_pkg::*; (
	input logic clk,
	input logic rst_n,
	// new load at the tail
	input logic ld_alloc,
	input addr_t ld_addr,
	// load finished, with or without store forwarding
	input logic ld_exec,
	input ldq_idx_t ld_exec_index,
	input logic ld_fwd,
	input stq_idx_t ld_fwd_index,
	// free the oldest load
	input logic ld_retire,
	// store queue state for snapshots and mask cleanup
	input logic [STQ_SIZE-1:0] stq_valid_mask,
	input logic stq_commit,
	input stq_idx_t stq_commit_index,
	// loads to replay, from the detector
	input logic [LDQ_SIZE-1:0] order_failures,
	output load_queue_entry [LDQ_SIZE-1:0] load_queue_entries,
	output ldq_idx_t ld_alloc_index,
	output logic ld_full
);

	localparam int CNT_W = $clog2(LDQ_SIZE) + 1;

	ldq_idx_t head;
	ldq_idx_t tail;
	logic [CNT_W-1:0] count;

	logic [LDQ_SIZE-1:0] valid;
	logic [LDQ_SIZE-1:0] succeeded;
	logic [LDQ_SIZE-1:0] fwd_data;
	logic [STQ_SIZE-1:0] store_mask [LDQ_SIZE];
	addr_t address [LDQ_SIZE];
	stq_idx_t fwd_index [LDQ_SIZE];

	// bit of the store leaving the queue this cycle
	logic [STQ_SIZE-1:0] commit_bit;

	assign commit_bit = stq_commit ? (STQ_SIZE'(1) << stq_commit_index) : '0;
	assign ld_alloc_index = tail;
	assign ld_full = (count == CNT_W'(LDQ_SIZE));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			valid <= '0;
			succeeded <= '0;
			fwd_data <= '0;
			for (int i = 0; i < LDQ_SIZE; i++) begin
				store_mask[i] <= '0;
			end
		end else begin
			// committed store is no longer older than anything
			for (int i = 0; i < LDQ_SIZE; i++) begin
				store_mask[i] <= store_mask[i] & ~commit_bit;
			end
			// flagged loads must replay
			succeeded <= succeeded & ~order_failures;
			if (ld_retire) begin
				valid[head] <= 1'b0;
				succeeded[head] <= 1'b0;
				head <= head + ldq_idx_t'(1);
			end
			// snapshot excludes a store committing in the same cycle
			if (ld_alloc) begin
				valid[tail] <= 1'b1;
				succeeded[tail] <= 1'b0;
				fwd_data[tail] <= 1'b0;
				store_mask[tail] <= stq_valid_mask & ~commit_bit;
				tail <= tail + ldq_idx_t'(1);
			end
			// a fresh execution overrides a failure landing in the same cycle
			if (ld_exec) begin
				succeeded[ld_exec_index] <= 1'b1;
				fwd_data[ld_exec_index] <= ld_fwd;
			end
			count <= count + CNT_W'(ld_alloc) - CNT_W'(ld_retire);
		end
	end

	// payload fields, ignored while the slot is invalid
	always_ff @(posedge clk) begin
		if (ld_alloc) begin
			address[tail] <= ld_addr;
		end
		if (ld_exec) begin
			fwd_index[ld_exec_index] <= ld_fwd_index;
		end
	end

	always_comb begin
		for (int i = 0; i < LDQ_SIZE; i++) begin
			load_queue_entries[i].valid = valid[i];
			load_queue_entries[i].succeeded = succeeded[i];
			load_queue_entries[i].address = address[i];
			load_queue_entries[i].store_mask = store_mask[i];
			load_queue_entries[i].forward_stq_data = fwd_data[i];
			load_queue_entries[i].forward_stq_index = fwd_index[i];
		end
	end

	// execution reports must refer to a live load
	a_exec_valid_entry: assert property (
		@(posedge clk) disable iff (!rst_n)
		ld_exec |-> valid[ld_exec_index]
	) else $error("load executed on an invalid load queue entry");

	a_no_alloc_when_full: assert property (
		@(posedge clk) disable iff (!rst_n)
		ld_alloc |-> !ld_full
	) else $error("load allocated while the load queue is full");

	a_no_retire_when_empty: assert property (
		@(posedge clk) disable iff (!rst_n)
		ld_retire |-> (count != '0)
	) else $error("load retired while the load queue is empty");

endmodule

//--- verilog/store_queue.sv
// store address ring, allocates at the tail and commits from the head for the searcher
`timescale 1ns/1ps

module store_queue
	import lsu_pkg::*; (
	input logic clk,
	input logic rst_n,
	// allocate a new store at the tail
	input logic st_alloc,
	input addr_t st_addr,
	// retire the store at the head
	input logic st_commit,
	output store_queue_entry [STQ_SIZE-1:0] store_queue_entries,
	output stq_idx_t stq_head,
	// live slots, used by the load queue for its snapshot
	output logic [STQ_SIZE-1:0] stq_valid_mask,
	// qualified commit strobe and the slot that commits
	output logic stq_commit,
	output stq_idx_t stq_commit_index,
	output logic st_full
);

	// one extra bit so a full ring is distinct from an empty one
	localparam int CNT_W = $clog2(STQ_SIZE) + 1;

	stq_idx_t head;
	stq_idx_t tail;
	logic [CNT_W-1:0] count;
	logic empty;

	logic [STQ_SIZE-1:0] valid;
	addr_t address [STQ_SIZE];

	assign empty = (count == '0);
	assign st_full = (count == CNT_W'(STQ_SIZE));

	// commit only counts when something is there to commit
	assign stq_commit = st_commit && !empty;
	assign stq_commit_index = head;
	assign stq_head = head;
	assign stq_valid_mask = valid;

	// pointers, occupancy and valid bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			valid <= '0;
		end else begin
			// head slot is freed at the edge closing the commit cycle
			if (stq_commit) begin
				valid[head] <= 1'b0;
				head <= head + stq_idx_t'(1);
			end
			// tail never equals head here unless the ring is empty
			if (st_alloc) begin
				valid[tail] <= 1'b1;
				tail <= tail + stq_idx_t'(1);
			end
			count <= count + CNT_W'(st_alloc) - CNT_W'(stq_commit);
		end
	end

	// address payload, only meaningful while valid
	always_ff @(posedge clk) begin
		if (st_alloc) begin
			address[tail] <= st_addr;
		end
	end

	// pack the slots for the detector
	always_comb begin
		for (int i = 0; i < STQ_SIZE; i++) begin
			store_queue_entries[i].valid = valid[i];
			store_queue_entries[i].address = address[i];
		end
	end

	// no back-pressure, the issuing side must respect full and empty
	a_no_alloc_when_full: assert property (
		@(posedge clk) disable iff (!rst_n)
		st_alloc |-> !st_full
	) else $error("store allocated while the store queue is full");

	a_no_commit_when_empty: assert property (
		@(posedge clk) disable iff (!rst_n)
		st_commit |-> !empty
	) else $error("store commit requested while the store queue is empty");

endmodule

//--- verilog/age_comparator.sv
// ring age compare, tells the detector whether one index is older than another
`timescale 1ns/1ps

module age_comparator #(
	// index width, ring size is 2**N
	parameter int N = 3
) (
	// oldest live slot of the ring
	input logic [N-1:0] head,
	input logic [N-1:0] a,
	input logic [N-1:0] b,
	// high when b is strictly older than a
	output logic result
);

	// distance of each index from the head, wraps modulo 2**N
	logic [N-1:0] dist_a;
	logic [N-1:0] dist_b;

	always_comb begin
		dist_a = a - head;
		dist_b = b - head;
	end

	// smaller distance means closer to the head, so older
	assign result = (dist_b < dist_a);

endmodule

//--- verilog/lsu_pkg.sv
// shared sizes, index types and queue entry layouts, imported by every lsu searcher block
package lsu_pkg;

	// ring depths, both powers of two so indices wrap naturally
	localparam int LDQ_SIZE = 8;
	localparam int STQ_SIZE = 8;

	// index into the load ring
	typedef logic [$clog2(LDQ_SIZE)-1:0] ldq_idx_t;

	// index into the store ring
	typedef logic [$clog2(STQ_SIZE)-1:0] stq_idx_t;

	// physical address as seen by the searcher
	typedef logic [31:0] addr_t;

	// one load queue slot
	typedef struct packed {
		// slot holds a live load
		logic valid;
		// load has produced and broadcast its data
		logic succeeded;
		// address the load read from
		addr_t address;
		// one bit per older store still in flight when the load was allocated
		logic [STQ_SIZE-1:0] store_mask;
		// data came from the store queue instead of the cache
		logic forward_stq_data;
		// store that supplied the forwarded data
		stq_idx_t forward_stq_index;
	} load_queue_entry;

	// one store queue slot, data and byte mask not modelled
	typedef struct packed {
		logic valid;
		addr_t address;
	} store_queue_entry;

endpackage
